//--- rtl/nora_settings.svh
//------------------------------
// Phase points assume a 6-phase CPU cycle on clk6x
// Address map follows the X16 layout with 128 RAM banks
//------------------------------
`ifndef NORA_SETTINGS_SVH
`define NORA_SETTINGS_SVH

// CPU cycle in clk6x ticks and the strobe phases inside it
`define CPU_CYCLE_LEN       6
`define PHI2_RISE_PHASE     3           // phi2 high from here to cycle end
`define LATCH_AD_PHASE      1
`define SETUP_CS_PHASE      2
`define RELEASE_WR_PHASE    5
`define RELEASE_CS_PHASE    0

// IO page and register groups inside it
`define IO_PAGE             8'h9F
`define VIA_GROUP           4'h0        // 9F00..9F0F
`define VERA_GROUP_LO       4'h2        // 9F20..
`define VERA_GROUP_HI       4'h3        // ..9F3F

// Banked RAM window and high address forming
`define BANK_WIN_TOP3       3'b101      // A000..BFFF
`define RAMBANK_MASK        8'h7F       // Only 128 banks usable
`define LOWMEM_MAH_TOP      5'b11111    // Low RAM sits at the top of SRAM

// VIA register indices
`define VIA_REG_ORB         4'd0
`define VIA_REG_ORA         4'd1
`define VIA_REG_DDRB        4'd2
`define VIA_REG_DDRA        4'd3

`define UNMAPPED_READ       8'hFF       // Open bus value

`endif

//--- rtl/nora_pkg.sv
//------------------------------
// Types shared by the bus glue
//------------------------------
package nora_pkg;

    // Address as it arrives on the CPU pins
    typedef struct packed {
        logic [3:0]  ca;        // A15..A12 from CA
        logic [11:0] mal;       // A11..A0 from MAL
    } cpu_addr_pins_t;

    // Same address seen by the decoder
    typedef struct packed {
        logic [7:0] page;       // A15..A8
        logic [3:0] grp;        // A7..A4, 16-byte register group
        logic [3:0] idx;        // A3..A0, register in group
    } cpu_addr_map_t;

    // Latched CPU address
    typedef union packed {
        cpu_addr_pins_t pins;
        cpu_addr_map_t  map;
    } cpu_addr_u;

endpackage

//--- rtl/nora_if.sv
//------------------------------
// Plain levels and pulses only
// No handshake on either bus
//------------------------------
`timescale 1ns/1ns

// Phase strobes from the phaser
interface phase_if;
    logic phi2;             // CPU clock
    logic latch_ad;         // Register address and rwn
    logic setup_cs;         // Open the access
    logic release_wr;       // End of write data window
    logic release_cs;       // Close the access

    modport src
    (
        output phi2,
        output latch_ad,
        output setup_cs,
        output release_wr,
        output release_cs
    );

    modport snk
    (
        input phi2,
        input latch_ad,
        input setup_cs,
        input release_wr,
        input release_cs
    );
endinterface

// Internal register bus
interface nora_slv_if;
    logic [3:0] idx;        // Register index, A3..A0
    logic [7:0] wdata;      // Good only with wvalid
    logic       wvalid;     // One clk6x pulse at release_wr
    logic       req;        // Held for the whole access
    logic       rwn;        // 1 = read
    logic [7:0] rdata;      // Combinational from idx

    modport master
    (
        output idx,
        output wdata,
        output wvalid,
        output req,
        output rwn,
        input  rdata
    );

    modport slave
    (
        input  idx,
        input  wdata,
        input  wvalid,
        input  req,
        input  rwn,
        output rdata
    );
endinterface

//--- rtl/cpu_phaser.sv
//------------------------------
// Free running and never stopped
// Strobes are one clk6x wide
//------------------------------
`timescale 1ns/1ns
`include "nora_settings.svh"

module cpu_phaser
(
    input  logic    clk6x,
    input  logic    rst_i,
    phase_if.src    ph
);
    localparam int PW = $clog2(`CPU_CYCLE_LEN);

    // Phase points at counter width
    localparam logic [PW-1:0] LAST_PH    = PW'(`CPU_CYCLE_LEN - 1);
    localparam logic [PW-1:0] PHI2_PH    = PW'(`PHI2_RISE_PHASE);
    localparam logic [PW-1:0] LATCH_PH   = PW'(`LATCH_AD_PHASE);
    localparam logic [PW-1:0] SETUP_PH   = PW'(`SETUP_CS_PHASE);
    localparam logic [PW-1:0] REL_WR_PH  = PW'(`RELEASE_WR_PHASE);
    localparam logic [PW-1:0] REL_CS_PH  = PW'(`RELEASE_CS_PHASE);

    logic [PW-1:0] phase_r;
    logic [PW-1:0] phase_nx;
    logic          phi2_r;
    logic          first_r;     // Still in the first cycle after reset

    // Modulo count
    always_comb
    begin
        if (phase_r == LAST_PH)
            phase_nx = '0;
        else
            phase_nx = phase_r + 1'b1;
    end

    always_ff @(posedge clk6x)
    begin
        if (rst_i)
        begin
            phase_r <= '0;
            phi2_r  <= 1'b0;
            first_r <= 1'b1;
        end
        else
        begin
            phase_r <= phase_nx;
            phi2_r  <= (phase_nx >= PHI2_PH);   // Registered so the CPU clock is clean
            if (phase_r == REL_CS_PH)
                first_r <= 1'b0;
        end
    end

    assign ph.phi2       = phi2_r;
    assign ph.latch_ad   = (phase_r == LATCH_PH);
    assign ph.setup_cs   = (phase_r == SETUP_PH);
    assign ph.release_wr = (phase_r == REL_WR_PH);

    // No access is open yet in the first phase 0
    assign ph.release_cs = (phase_r == REL_CS_PH) && !first_r;

endmodule

//--- rtl/bus_controller.sv
//------------------------------
// One access per CPU cycle with no wait states
// CPU owns MAL, only A20..A12 come from here
//------------------------------
`timescale 1ns/1ns
`include "nora_settings.svh"

module bus_controller
    import nora_pkg::*;
(
    input  logic        clk6x,
    input  logic        rst_i,
    phase_if.snk        ph,
    nora_slv_if.master  slv,
    // CPU side
    input  logic [3:0]  ca_i,       // A15..A12
    input  logic [11:0] mal_i,      // A11..A0, shared with SRAM
    input  logic        crwn_i,
    input  logic [7:0]  cd_i,
    output logic [7:0]  cd_o,
    output logic        cd_oe_o,
    // Memory side
    input  logic [7:0]  md_i,
    output logic [7:0]  md_o,
    output logic        md_oe_o,
    output logic [8:0]  mah_o,      // A20..A12
    output logic        m1csn_o,
    output logic        mrdn_o,
    output logic        mwrn_o,
    output logic        vcs0n_o
);
    cpu_addr_u  addr_r;
    logic       rwn_r;
    logic       acc_active_r;       // Between setup_cs and release_cs
    logic       m1csn_r;
    logic       vcs0n_r;
    logic       mrdn_r;
    logic       mwrn_r;
    logic [7:0] bank_r;             // RAM bank at 0000
    logic [8:0] mah_r;
    logic       is_io;
    logic       sel_via;
    logic       sel_vera;
    logic       sel_bank;
    logic       sel_sram;
    logic       sel_ext;            // Device outside the FPGA

    // Address capture
    always_ff @(posedge clk6x)
    begin
        if (ph.latch_ad)
        begin
            addr_r.pins.ca  <= ca_i;
            addr_r.pins.mal <= mal_i;
        end
    end

    always_ff @(posedge clk6x)
    begin
        if (rst_i)
            rwn_r <= 1'b1;
        else if (ph.latch_ad)
            rwn_r <= crwn_i;
    end

    // Decode on the map view
    always_comb
    begin
        is_io    = (addr_r.map.page == `IO_PAGE);
        sel_via  = is_io && (addr_r.map.grp == `VIA_GROUP);
        sel_vera = is_io && (addr_r.map.grp >= `VERA_GROUP_LO)
                         && (addr_r.map.grp <= `VERA_GROUP_HI);
        sel_bank = (addr_r.pins == 16'h0000);   // Bank register
        sel_sram = !is_io && !sel_bank;
        sel_ext  = sel_sram || sel_vera;
    end

    // Selects and strobes
    always_ff @(posedge clk6x)
    begin
        if (rst_i)
        begin
            acc_active_r <= 1'b0;
            m1csn_r      <= 1'b1;
            vcs0n_r      <= 1'b1;
            mrdn_r       <= 1'b1;
            mwrn_r       <= 1'b1;
        end
        else
        begin
            if (ph.setup_cs)
            begin
                acc_active_r <= 1'b1;
                m1csn_r      <= !sel_sram;
                vcs0n_r      <= !sel_vera;
                mrdn_r       <= !(sel_ext && rwn_r);
                mwrn_r       <= !(sel_ext && !rwn_r);
            end
            else if (ph.release_cs)
            begin
                acc_active_r <= 1'b0;
                m1csn_r      <= 1'b1;
                vcs0n_r      <= 1'b1;
                mrdn_r       <= 1'b1;
            end
            if (ph.release_wr)
                mwrn_r <= 1'b1;     // Ends before CS for data hold
        end
    end

    // Bank register write
    always_ff @(posedge clk6x)
    begin
        if (rst_i)
            bank_r <= 8'h00;
        else if (ph.release_wr && acc_active_r && sel_bank && !rwn_r)
            bank_r <= cd_i & `RAMBANK_MASK;
    end

    // High address, kept as is outside SRAM
    always_ff @(posedge clk6x)
    begin
        if (ph.setup_cs && sel_sram)
        begin
            if (addr_r.map.page[7:5] == `BANK_WIN_TOP3)
                mah_r <= {bank_r, addr_r.map.page[4]};      // Bank window
            else
                mah_r <= {`LOWMEM_MAH_TOP, addr_r.map.page[7:4]};
        end
    end

    // Read data back to the CPU
    always_comb
    begin
        if (sel_bank)
            cd_o = bank_r;
        else if (sel_ext)
            cd_o = md_i;            // SRAM or VERA
        else if (sel_via)
            cd_o = slv.rdata;
        else
            cd_o = `UNMAPPED_READ;
    end

    assign cd_oe_o = ph.phi2 && rwn_r;      // Drive CD in phi2 high on reads
    assign md_o    = cd_i;
    assign md_oe_o = acc_active_r && !rwn_r;

    // Register bus toward the VIA
    assign slv.idx    = addr_r.map.idx;
    assign slv.wdata  = cd_i;
    assign slv.rwn    = rwn_r;
    assign slv.req    = acc_active_r && sel_via;
    assign slv.wvalid = ph.release_wr && slv.req && !rwn_r;

    assign mah_o   = mah_r;
    assign m1csn_o = m1csn_r;
    assign vcs0n_o = vcs0n_r;
    assign mrdn_o  = mrdn_r;
    assign mwrn_o  = mwrn_r;

endmodule

//--- rtl/simple_via.sv
//------------------------------
// GPIO only with no timers, shift register or IRQ
//------------------------------
`timescale 1ns/1ns
`include "nora_settings.svh"

module simple_via
(
    input  logic        clk6x,
    input  logic        rst_i,
    nora_slv_if.slave   slv,
    input  logic [7:0]  ira_i,      // Pin levels port A
    input  logic [7:0]  irb_i,      // Pin levels port B
    output logic [7:0]  ora_o,
    output logic [7:0]  orb_o,
    output logic [7:0]  ddra_o,     // 1 = output
    output logic [7:0]  ddrb_o
);
    logic [7:0] ora_r;
    logic [7:0] orb_r;
    logic [7:0] ddra_r;
    logic [7:0] ddrb_r;
    logic       wr_en;

    assign wr_en = slv.req && slv.wvalid && !slv.rwn;

    // Register writes
    always_ff @(posedge clk6x)
    begin
        if (rst_i)
        begin
            ora_r  <= 8'h00;
            orb_r  <= 8'h00;
            ddra_r <= 8'h00;        // All pins input after reset
            ddrb_r <= 8'h00;
        end
        else if (wr_en)
        begin
            case (slv.idx)
                `VIA_REG_ORB:  orb_r  <= slv.wdata;
                `VIA_REG_ORA:  ora_r  <= slv.wdata;
                `VIA_REG_DDRB: ddrb_r <= slv.wdata;
                `VIA_REG_DDRA: ddra_r <= slv.wdata;
                default:       ;    // Other registers not present
            endcase
        end
    end

    // Read mux
    always_comb
    begin
        case (slv.idx)
            // Output bits from the register, input bits from the pins
            `VIA_REG_ORB:  slv.rdata = (orb_r & ddrb_r) | (irb_i & ~ddrb_r);
            `VIA_REG_ORA:  slv.rdata = (ora_r & ddra_r) | (ira_i & ~ddra_r);
            `VIA_REG_DDRB: slv.rdata = ddrb_r;
            `VIA_REG_DDRA: slv.rdata = ddra_r;
            default:       slv.rdata = 8'h00;
        endcase
    end

    assign ora_o  = ora_r;
    assign orb_o  = orb_r;
    assign ddra_o = ddra_r;
    assign ddrb_o = ddrb_r;

endmodule

//--- rtl/nora_top.sv
//------------------------------
// Board wrapper owns the tri-states and makes clk6x and rst_i
// SDA is input only
//------------------------------
`timescale 1ns/1ns

module nora_top
(
    input  logic        clk6x,
    input  logic        rst_i,
    // CPU bus
    input  logic [3:0]  ca_i,
    input  logic [11:0] mal_i,
    input  logic        crwn_i,
    input  logic [7:0]  cd_i,
    output logic [7:0]  cd_o,
    output logic        cd_oe_o,
    output logic        cphi2_o,
    // Memory bus
    input  logic [7:0]  md_i,
    output logic [7:0]  md_o,
    output logic        md_oe_o,
    output logic [8:0]  mah_o,
    output logic        m1csn_o,
    output logic        mrdn_o,
    output logic        mwrn_o,
    output logic        vcs0n_o,
    // NES pad
    input  logic        nes_data0_i,
    input  logic        nes_data1_i,
    output logic        nes_latch_o,
    output logic        nes_clock_o,
    // I2C
    input  logic        i2c_scl_i,
    output logic        i2c_scl_o,
    output logic        i2c_scl_oe_o,
    input  logic        i2c_sda_i,
    // LEDs
    output logic        cpuled0_o,
    output logic        cpuled1_o
);
    logic [7:0] via_ora;
    logic [7:0] via_orb;
    logic [7:0] via_ira;
    logic [7:0] via_irb;
    logic [7:0] via_ddra;
    logic [7:0] via_ddrb;

    phase_if    ph ();
    nora_slv_if slv ();

    cpu_phaser u_phaser
    (
        .clk6x (clk6x),
        .rst_i (rst_i),
        .ph    (ph)
    );

    bus_controller u_busctrl
    (
        .clk6x   (clk6x),
        .rst_i   (rst_i),
        .ph      (ph),
        .slv     (slv),
        .ca_i    (ca_i),
        .mal_i   (mal_i),
        .crwn_i  (crwn_i),
        .cd_i    (cd_i),
        .cd_o    (cd_o),
        .cd_oe_o (cd_oe_o),
        .md_i    (md_i),
        .md_o    (md_o),
        .md_oe_o (md_oe_o),
        .mah_o   (mah_o),
        .m1csn_o (m1csn_o),
        .mrdn_o  (mrdn_o),
        .mwrn_o  (mwrn_o),
        .vcs0n_o (vcs0n_o)
    );

    simple_via u_via
    (
        .clk6x  (clk6x),
        .rst_i  (rst_i),
        .slv    (slv),
        .ira_i  (via_ira),
        .irb_i  (via_irb),
        .ora_o  (via_ora),
        .orb_o  (via_orb),
        .ddra_o (via_ddra),
        .ddrb_o (via_ddrb)
    );

    assign cphi2_o = ph.phi2;

    // Pad strobes are inverted and idle high
    assign nes_clock_o  = via_ddra[3] ? ~via_ora[3] : 1'b1;
    assign nes_latch_o  = via_ddra[2] ? ~via_ora[2] : 1'b1;
    assign i2c_scl_o    = via_ora[1];
    assign i2c_scl_oe_o = via_ddra[1];          // Released when input
    assign cpuled0_o    = via_ddrb[0] ? via_orb[0] : 1'b1;
    assign cpuled1_o    = via_ddrb[1] ? via_orb[1] : 1'b1;

    // Port inputs read back pin state
    assign via_ira = {nes_data0_i, nes_data1_i, 2'b11, ~nes_clock_o, ~nes_latch_o,
                      i2c_scl_i, i2c_sda_i};
    assign via_irb = {6'b110000, cpuled1_o, cpuled0_o};

endmodule

//--- sim/tb_nora.sv
//------------------------------
// Reads sim/nora_tests.txt from the project root
// Stops at the first wrong value
//------------------------------
`timescale 1ns/1ns

module tb_nora;
    localparam int CLK_PER = 100;
    localparam int RST_CYC = 10;

    logic        clk6x;
    logic        rst_i;
    logic [3:0]  ca_i;
    logic [11:0] mal_i;
    logic        crwn_i;
    logic [7:0]  cd_i;
    logic [7:0]  cd_o;
    logic        cd_oe_o;
    logic        cphi2_o;
    logic [7:0]  md_i;
    logic [7:0]  md_o;
    logic        md_oe_o;
    logic [8:0]  mah_o;
    logic        m1csn_o;
    logic        mrdn_o;
    logic        mwrn_o;
    logic        vcs0n_o;
    logic        nes_data0_i;
    logic        nes_data1_i;
    logic        nes_latch_o;
    logic        nes_clock_o;
    logic        i2c_scl_i;
    logic        i2c_scl_o;
    logic        i2c_scl_oe_o;
    logic        i2c_sda_i;
    logic        cpuled0_o;
    logic        cpuled1_o;

    logic [7:0]  sram [logic [20:0]];  // Keyed by {mah, mal}
    byte         t_op [$];
    logic [15:0] t_addr [$];
    logic [7:0]  t_data [$];
    logic [7:0]  t_rd [$];
    logic [8:0]  t_mah [$];
    logic [1:0]  t_cs [$];             // 0 none, 1 SRAM, 2 VERA
    int          n_tests;
    bit          loaded;
    logic [1:0]  prev_cs;

    nora_top dut
    (
        .clk6x        (clk6x),
        .rst_i        (rst_i),
        .ca_i         (ca_i),
        .mal_i        (mal_i),
        .crwn_i       (crwn_i),
        .cd_i         (cd_i),
        .cd_o         (cd_o),
        .cd_oe_o      (cd_oe_o),
        .cphi2_o      (cphi2_o),
        .md_i         (md_i),
        .md_o         (md_o),
        .md_oe_o      (md_oe_o),
        .mah_o        (mah_o),
        .m1csn_o      (m1csn_o),
        .mrdn_o       (mrdn_o),
        .mwrn_o       (mwrn_o),
        .vcs0n_o      (vcs0n_o),
        .nes_data0_i  (nes_data0_i),
        .nes_data1_i  (nes_data1_i),
        .nes_latch_o  (nes_latch_o),
        .nes_clock_o  (nes_clock_o),
        .i2c_scl_i    (i2c_scl_i),
        .i2c_scl_o    (i2c_scl_o),
        .i2c_scl_oe_o (i2c_scl_oe_o),
        .i2c_sda_i    (i2c_sda_i),
        .cpuled0_o    (cpuled0_o),
        .cpuled1_o    (cpuled1_o)
    );

    always #(CLK_PER / 2) clk6x = ~clk6x;

    // SRAM and VERA answer a small delay after the edge
    always
    begin
        @(posedge clk6x);
        #5;
        if (!mrdn_o && !m1csn_o)
            md_i = sram.exists({mah_o, mal_i}) ? sram[{mah_o, mal_i}] : 8'h00;
        else if (!mrdn_o && !vcs0n_o)
            md_i = 8'hA5;                   // VERA stand-in
        else
            md_i = 8'h00;
    end

    // SRAM takes data at the end of the write strobe
    always @(posedge mwrn_o)
    begin
        if (!rst_i && !m1csn_o)
            sram[{mah_o, mal_i}] = md_o;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("Done: errors found");
            $fatal(1, "stopped at first error");
        end
    endtask

    // One CPU cycle, entered just after phi2 falls
    task automatic cpu_access(input byte op, input logic [15:0] addr, input logic [7:0] data,
                              input logic [7:0] exp_rd, input logic [8:0] exp_mah,
                              input logic [1:0] cs);
        logic rd;
        rd     = (op == "R");
        ca_i   = addr[15:12];
        mal_i  = addr[11:0];
        crwn_i = rd;
        cd_i   = rd ? 8'h00 : data;
        for (int p = 0; p < 6; p++)
        begin
            @(negedge clk6x);
            check("cphi2_o", 32'(cphi2_o), 32'(p >= 3));
            if (p == 0)
            begin
                // Previous access still selected here
                check("m1csn_o", 32'(m1csn_o), 32'(!(prev_cs == 2'd1)));
                check("vcs0n_o", 32'(vcs0n_o), 32'(!(prev_cs == 2'd2)));
                check("mwrn_o", 32'(mwrn_o), 32'd1);
            end
            else if (p < 3)
            begin
                check("m1csn_o", 32'(m1csn_o), 32'd1);
                check("vcs0n_o", 32'(vcs0n_o), 32'd1);
            end
            else
            begin
                check("m1csn_o", 32'(m1csn_o), 32'(!(cs == 2'd1)));
                check("vcs0n_o", 32'(vcs0n_o), 32'(!(cs == 2'd2)));
                check("mrdn_o", 32'(mrdn_o), 32'(!(cs != 2'd0 && rd)));
                check("mwrn_o", 32'(mwrn_o), 32'(!(cs != 2'd0 && !rd)));
                check("md_oe_o", 32'(md_oe_o), 32'(!rd));
                check("cd_oe_o", 32'(cd_oe_o), 32'(rd));
            end
            if (p == 3 && cs == 2'd1)
                check("mah_o", 32'(mah_o), 32'(exp_mah));
            if (p == 4 && rd)
                check("cd_o", 32'(cd_o), 32'(exp_rd));
        end
        prev_cs = cs;
        @(posedge clk6x);
        #5;
    endtask

    // Pin inputs {nes0, nes1, scl, sda}, outputs {latch, clock, scl, oe, led1, led0}
    task automatic pin_set(input logic [3:0] pins, input logic [5:0] exp_out);
        {nes_data0_i, nes_data1_i, i2c_scl_i, i2c_sda_i} = pins;
        #10;
        check("gpio_out", 32'({nes_latch_o, nes_clock_o, i2c_scl_o, i2c_scl_oe_o,
                               cpuled1_o, cpuled0_o}), 32'(exp_out));
    endtask

    task automatic load_tests();
        int          fd;
        string       line;
        string       op_s;
        logic [15:0] a;
        logic [7:0]  d;
        logic [7:0]  r;
        logic [8:0]  m;
        logic [1:0]  c;
        fd = $fopen("sim/nora_tests.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the test data file sim/nora_tests.txt");
            $display("Done: errors found");
            $fatal(1, "no test data");
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line.getc(0) == 8'h23)
                continue;               // Blank or comment
            if ($sscanf(line, "%s %h %h %h %h %h", op_s, a, d, r, m, c) == 6)
            begin
                t_op.push_back(op_s.getc(0));
                t_addr.push_back(a);
                t_data.push_back(d);
                t_rd.push_back(r);
                t_mah.push_back(m);
                t_cs.push_back(c);
            end
        end
        $fclose(fd);
        n_tests = t_op.size();
    endtask

    // Watchdog sized from the number of test lines
    initial
    begin
        wait (loaded);
        #((RST_CYC + 2 * n_tests * 6) * CLK_PER);
        $display("timeout: the test sequence did not finish in time");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        clk6x = 1'b0;
        rst_i = 1'b1;
        {ca_i, mal_i, crwn_i, cd_i, md_i} = {4'h0, 12'h000, 1'b1, 8'h00, 8'h00};
        {nes_data0_i, nes_data1_i, i2c_scl_i, i2c_sda_i} = 4'h0;
        prev_cs = 2'd0;
        loaded = 1'b0;
        load_tests();
        loaded = 1'b1;
        repeat (RST_CYC - 1) @(posedge clk6x);
        @(negedge clk6x);
        check("cphi2_o", 32'(cphi2_o), 32'd0);
        check("selects", 32'({m1csn_o, vcs0n_o, mrdn_o, mwrn_o}), 32'hF);
        check("oe", 32'({cd_oe_o, md_oe_o, i2c_scl_oe_o}), 32'd0);
        check("gpio_idle", 32'({nes_latch_o, nes_clock_o, cpuled1_o, cpuled0_o}), 32'hF);
        @(posedge clk6x);
        #5 rst_i = 1'b0;
        @(negedge cphi2_o);
        #5;
        for (int i = 0; i < n_tests; i++)
        begin
            if (t_op[i] == "S")
                pin_set(t_addr[i][3:0], t_data[i][5:0]);
            else
                cpu_access(t_op[i], t_addr[i], t_data[i], t_rd[i], t_mah[i], t_cs[i]);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- tb.f
+incdir+rtl
rtl/nora_pkg.sv
rtl/nora_if.sv
rtl/cpu_phaser.sv
rtl/bus_controller.sv
rtl/simple_via.sv
rtl/nora_top.sv
sim/tb_nora.sv

//--- Makefile
# Verilator build and run of the bus glue testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove build output and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module tb_nora -f tb.f -o tb_nora
	./obj_dir/tb_nora | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/nora_tests.txt
# op addr data exp_rd exp_mah cs, hex; cs 0 none, 1 SRAM, 2 VERA
# S lines: addr = {nes0,nes1,scl,sda}, data = expected {latch,clock,scl,scl_oe,led1,led0}
W 1234 5A 00 1F1 1
R 1234 00 5A 1F1 1
W C000 3C 00 1FC 1
W 9EFF 81 00 1F9 1
W FFF0 E7 00 1FF 1
R C000 00 3C 1FC 1
R 9EFF 00 81 1F9 1
R FFF0 00 E7 1FF 1
W 0000 95 00 000 0
R 0000 00 15 000 0
W A010 11 00 02A 1
W B010 22 00 02B 1
W 0000 93 00 000 0
R 0000 00 13 000 0
W A010 33 00 026 1
R A010 00 33 026 1
W 0000 15 00 000 0
R A010 00 11 02A 1
R B010 00 22 02B 1
W 9F03 0E 00 000 0
W 9F01 0C 00 000 0
W 9F02 03 00 000 0
W 9F00 02 00 000 0
S 0 06 00 000 0
W 9F01 02 00 000 0
S 0 3E 00 000 0
R 9F02 00 03 000 0
R 9F03 00 0E 000 0
W 9F03 00 00 000 0
W 9F02 00 00 000 0
S A 3B 00 000 0
R 9F01 00 B2 000 0
S 5 3B 00 000 0
R 9F01 00 71 000 0
R 9F02 00 00 000 0
W 9F20 44 00 000 2
R 9F3F 00 A5 000 2
R 9F80 00 FF 000 0
R 9F10 00 FF 000 0
